// ==== neoIoPkg.sv ====
package neoIoPkg;

	// 68K word addresses, bits 23:1 of the byte address
	localparam logic [23:1] DIPSW_ADDR     = 23'h180000;	// 0x300000, DIP switch read
	localparam logic [23:1] LED_DATA_ADDR  = 23'h1C0020;	// 0x380040, LED/EL data byte
	localparam logic [23:1] LED_LATCH_ADDR = 23'h1C0018;	// 0x380030, latch command

	// Memory card window, 0x800000 to 0x83FFFF
	localparam logic [23:1] CARD_BASE  = 23'h400000;
	localparam logic [23:1] CARD_LIMIT = 23'h41FFFF;
	localparam int CARD_ADDR_W = 17;	// Word offset inside the window

	// Wait states per region
	localparam int WAIT_W = 3;
	localparam logic [WAIT_W-1:0] CAB_WAITS  = 3'd0;	// Cabinet and unmapped
	localparam logic [WAIT_W-1:0] CARD_WAITS = 3'd2;	// Card needs slower strobes

	localparam logic [15:0] OPEN_BUS = 16'hFFFF;	// Nothing drives the bus

	// Bus controller states
	typedef enum logic [1:0]
	{
		IDLE,		// Waiting for AS and a data strobe
		DECODE,		// Address decode, one cycle
		WAIT,		// Wait timer running
		ACK			// DTACK low until AS released
	} busState_e;

	// Selected region of the current cycle
	typedef enum logic [2:0]
	{
		REG_NONE,
		REG_DIP,
		REG_LEDDATA,
		REG_LEDLATCH,
		REG_CARD
	} region_e;

	// Low data byte as seen by the cabinet port
	typedef union packed
	{
		logic [7:0] raw;	// LED data write
		struct packed
		{
			logic [4:0] reserved;
			logic loadLed2;
			logic loadLed1;
			logic loadEl;
		} ctrl;				// Latch command write
	} ledWord_u;

endpackage

// ==== neoWaitTimer.sv ====
`timescale 1ns/10ps

module neoWaitTimer
(
	input  logic mclk,
	input  logic rst,
	input  logic timerStart,
	input  logic [neoIoPkg::WAIT_W-1:0] waitLoad,
	output logic timerDone
);

	logic [neoIoPkg::WAIT_W-1:0] count;
	logic busy;

	always_ff @(posedge mclk)
	begin
		if (rst)
		begin
			count <= '0;
			busy <= 1'b0;
			timerDone <= 1'b0;
		end
		else
		begin
			timerDone <= 1'b0;						// Single cycle pulse
			if (timerStart)
			begin
				if (waitLoad == '0)
					timerDone <= 1'b1;				// No wait states, done next cycle
				else
				begin
					count <= waitLoad;
					busy <= 1'b1;
				end
			end
			else if (busy)
			begin
				if (count == neoIoPkg::WAIT_W'(1))
				begin
					timerDone <= 1'b1;				// load+1 cycles after start
					busy <= 1'b0;
				end
				count <= count - 1'b1;
			end
		end
	end

	// Bus controller must not restart a running count
	assert property (@(posedge mclk) disable iff (rst) timerStart |-> !busy);

endmodule

// ==== neoBusCtrl.sv ====
`timescale 1ns/10ps

module neoBusCtrl
(
	input  logic mclk,
	input  logic rst,
	input  logic [23:1] addr,
	input  logic rw,									// High = read
	input  logic nAs,
	input  logic nUds,
	input  logic nLds,
	input  logic timerDone,
	input  logic [15:0] cabData,
	input  logic [15:0] cardData,
	output neoIoPkg::region_e region,
	output logic access,								// First WAIT cycle
	output logic wrStrobe,								// Same cycle, writes only
	output logic timerStart,
	output logic [neoIoPkg::WAIT_W-1:0] waitLoad,
	output logic [15:0] dataOut,
	output logic nDtack
);

	neoIoPkg::busState_e state;
	neoIoPkg::region_e decRegion;
	logic cycleStart;

	// AS plus at least one lane
	assign cycleStart = !nAs && (!nUds || !nLds);

	// Address map
	always_comb
	begin
		if (addr == neoIoPkg::DIPSW_ADDR)
			decRegion = neoIoPkg::REG_DIP;
		else if (addr == neoIoPkg::LED_DATA_ADDR)
			decRegion = neoIoPkg::REG_LEDDATA;
		else if (addr == neoIoPkg::LED_LATCH_ADDR)
			decRegion = neoIoPkg::REG_LEDLATCH;
		else if (addr >= neoIoPkg::CARD_BASE && addr <= neoIoPkg::CARD_LIMIT)
			decRegion = neoIoPkg::REG_CARD;
		else
			decRegion = neoIoPkg::REG_NONE;	// Still acked, reads open bus
	end

	always_ff @(posedge mclk)
	begin
		if (rst)
		begin
			state <= neoIoPkg::IDLE;
			region <= neoIoPkg::REG_NONE;
			waitLoad <= '0;
			access <= 1'b0;
			wrStrobe <= 1'b0;
			timerStart <= 1'b0;
			nDtack <= 1'b1;
		end
		else
		begin
			access <= 1'b0;				// Pulses by default
			wrStrobe <= 1'b0;
			timerStart <= 1'b0;
			case (state)
				neoIoPkg::IDLE:
					if (cycleStart)
						state <= neoIoPkg::DECODE;
				neoIoPkg::DECODE:
				begin
					region <= decRegion;
					waitLoad <= (decRegion == neoIoPkg::REG_CARD) ?
						neoIoPkg::CARD_WAITS : neoIoPkg::CAB_WAITS;
					timerStart <= 1'b1;
					access <= 1'b1;
					wrStrobe <= !rw;
					state <= neoIoPkg::WAIT;
				end
				neoIoPkg::WAIT:
					if (timerDone)
					begin
						nDtack <= 1'b0;		// Access complete
						state <= neoIoPkg::ACK;
					end
				neoIoPkg::ACK:
					if (nAs)					// Master ended the cycle
					begin
						nDtack <= 1'b1;
						state <= neoIoPkg::IDLE;
					end
				default:
					state <= neoIoPkg::IDLE;
			endcase
		end
	end

	// Read word, latched as DTACK falls
	always_ff @(posedge mclk)
	begin
		if (state == neoIoPkg::WAIT && timerDone)
		begin
			case (region)
				neoIoPkg::REG_DIP:  dataOut <= cabData;
				neoIoPkg::REG_CARD: dataOut <= cardData;
				default:            dataOut <= neoIoPkg::OPEN_BUS;	// LED ports are write only
			endcase
		end
	end

	// DTACK released on the clock after AS goes high
	assert property (@(posedge mclk) disable iff (rst) (nAs && !nDtack) |=> nDtack);

	// Timer answers only while the FSM waits for it
	assert property (@(posedge mclk) disable iff (rst)
		timerDone |-> state == neoIoPkg::WAIT);

endmodule

// ==== neoCabIo.sv ====
`timescale 1ns/10ps

module neoCabIo
(
	input  logic mclk,
	input  logic rst,
	input  neoIoPkg::region_e region,
	input  logic wrStrobe,
	input  logic [15:0] dataIn,
	input  logic nLds,
	input  logic [7:0] dipSw,
	output logic [15:0] cabData,
	output logic [3:0] elOut,
	output logic [7:0] ledOut1,
	output logic [7:0] ledOut2
);

	neoIoPkg::ledWord_u ledWord;	// Low lane seen two ways
	logic [7:0] ledData;			// Stored byte waiting for a latch command
	logic dataWr;
	logic latchWr;

	assign ledWord.raw = dataIn[7:0];

	// Switches on the low lane only
	assign cabData = (region == neoIoPkg::REG_DIP) ? {8'hFF, dipSw} : neoIoPkg::OPEN_BUS;

	assign dataWr = wrStrobe && (region == neoIoPkg::REG_LEDDATA) && !nLds;
	assign latchWr = wrStrobe && (region == neoIoPkg::REG_LEDLATCH);

	// Data register
	always_ff @(posedge mclk)
	begin
		if (dataWr)
			ledData <= ledWord.raw;
	end

	// Output latches, any combination per command
	always_ff @(posedge mclk)
	begin
		if (rst)
		begin
			elOut <= '0;
			ledOut1 <= '0;
			ledOut2 <= '0;
		end
		else if (latchWr)
		begin
			if (ledWord.ctrl.loadEl)
				elOut <= ledData[3:0];		// EL panel uses the low nibble
			if (ledWord.ctrl.loadLed1)
				ledOut1 <= ledData;
			if (ledWord.ctrl.loadLed2)
				ledOut2 <= ledData;
		end
	end

endmodule

// ==== neoMemcard.sv ====
`timescale 1ns/10ps

module neoMemcard
(
	input  logic mclk,
	input  logic rst,
	input  neoIoPkg::region_e region,
	input  logic access,
	input  logic wrStrobe,
	input  logic rw,
	input  logic [23:1] addr,
	input  logic [15:0] dataIn,
	input  logic nLds,
	input  logic [7:0] cardDataIn,
	input  logic nCd1,
	input  logic nCd2,
	input  logic nWp,
	output logic [15:0] cardData,
	output logic [neoIoPkg::CARD_ADDR_W-1:0] cardAddr,
	output logic [7:0] cardDataOut,
	output logic nCrdc,
	output logic nCrdo,
	output logic nCardWe,
	output logic cardDataOe
);

	logic [23:1] wordOffset;
	logic [neoIoPkg::WAIT_W-1:0] holdCnt;	// Strobe time left
	logic busy;
	logic cardPresent;
	logic cardHit;

	assign wordOffset = addr - neoIoPkg::CARD_BASE;
	assign cardPresent = !nCd1 && !nCd2;		// Both detect pins grounded
	assign cardHit = access && (region == neoIoPkg::REG_CARD);

	// Card strobes
	always_ff @(posedge mclk)
	begin
		if (rst)
		begin
			nCrdc <= 1'b1;
			nCrdo <= 1'b1;
			nCardWe <= 1'b1;
			cardDataOe <= 1'b0;
			holdCnt <= '0;
			busy <= 1'b0;
		end
		else if (cardHit && cardPresent)
		begin
			nCrdc <= 1'b0;
			nCrdo <= !rw;
			busy <= 1'b1;
			holdCnt <= neoIoPkg::CARD_WAITS;
			if (wrStrobe && nWp && !nLds)	// Protected card is never written
			begin
				nCardWe <= 1'b0;
				cardDataOe <= 1'b1;
			end
		end
		else if (busy)
		begin
			if (holdCnt == '0)
			begin
				nCrdc <= 1'b1;				// End of access, with DTACK
				nCrdo <= 1'b1;
				cardDataOe <= 1'b0;
				busy <= 1'b0;
			end
			else
			begin
				if (holdCnt == neoIoPkg::WAIT_W'(1))
					nCardWe <= 1'b1;		// WE rises one cycle before CE
				holdCnt <= holdCnt - 1'b1;
			end
		end
	end

	// Address, write byte and read word
	always_ff @(posedge mclk)
	begin
		if (cardHit)
		begin
			cardAddr <= wordOffset[neoIoPkg::CARD_ADDR_W:1];
			cardDataOut <= dataIn[7:0];
			if (!cardPresent)
				cardData <= neoIoPkg::OPEN_BUS;
		end
		else if (busy && !nCrdo && holdCnt != '0)
			cardData <= {8'hFF, cardDataIn};	// Byte wide card
	end

	// Read and write strobes exclusive
	assert property (@(posedge mclk) disable iff (rst) !nCardWe |-> nCrdo);

endmodule

// ==== neoIoTop.sv ====
`timescale 1ns/10ps

module neoIoTop
(
	input  logic mclk,
	input  logic rst,
	// 68K side
	input  logic [23:1] addr,
	input  logic [15:0] dataIn,
	input  logic rw,
	input  logic nAs,
	input  logic nUds,
	input  logic nLds,
	output logic [15:0] dataOut,
	output logic nDtack,
	// Memory card
	output logic [neoIoPkg::CARD_ADDR_W-1:0] cardAddr,
	output logic [7:0] cardDataOut,
	output logic nCrdc,
	output logic nCrdo,
	output logic nCardWe,
	output logic cardDataOe,
	input  logic [7:0] cardDataIn,
	input  logic nCd1,
	input  logic nCd2,
	input  logic nWp,
	// Cabinet
	input  logic [7:0] dipSw,
	output logic [3:0] elOut,
	output logic [7:0] ledOut1,
	output logic [7:0] ledOut2
);

	neoIoPkg::region_e region;
	logic access;
	logic wrStrobe;
	logic timerStart;
	logic timerDone;
	logic [neoIoPkg::WAIT_W-1:0] waitLoad;
	logic [15:0] cabData;
	logic [15:0] cardData;

	neoBusCtrl i_busCtrl
	(
		.mclk(mclk), .rst(rst), .addr(addr), .rw(rw),
		.nAs(nAs), .nUds(nUds), .nLds(nLds), .timerDone(timerDone),
		.cabData(cabData), .cardData(cardData), .region(region), .access(access),
		.wrStrobe(wrStrobe), .timerStart(timerStart), .waitLoad(waitLoad),
		.dataOut(dataOut), .nDtack(nDtack)
	);

	neoWaitTimer i_waitTimer
	(
		.mclk(mclk), .rst(rst), .timerStart(timerStart), .waitLoad(waitLoad),
		.timerDone(timerDone)
	);

	neoCabIo i_cabIo
	(
		.mclk(mclk), .rst(rst), .region(region), .wrStrobe(wrStrobe),
		.dataIn(dataIn), .nLds(nLds), .dipSw(dipSw), .cabData(cabData),
		.elOut(elOut), .ledOut1(ledOut1), .ledOut2(ledOut2)
	);

	neoMemcard i_memcard
	(
		.mclk(mclk), .rst(rst), .region(region), .access(access),
		.wrStrobe(wrStrobe), .rw(rw), .addr(addr), .dataIn(dataIn), .nLds(nLds),
		.cardDataIn(cardDataIn), .nCd1(nCd1), .nCd2(nCd2), .nWp(nWp),
		.cardData(cardData), .cardAddr(cardAddr), .cardDataOut(cardDataOut),
		.nCrdc(nCrdc), .nCrdo(nCrdo), .nCardWe(nCardWe), .cardDataOe(cardDataOe)
	);

endmodule

// ==== neoMemcardModel.sv ====
`timescale 1ns/10ps

module neoMemcardModel
(
	input  logic [neoIoPkg::CARD_ADDR_W-1:0] cardAddr,
	input  logic [7:0] cardDataOut,
	input  logic nCrdc,
	input  logic nCrdo,
	input  logic nCardWe,
	input  logic cardDataOe,
	input  logic [1:0] inserted,		// One bit per detect pin
	input  logic protect,				// Write-protect tab
	output logic [7:0] cardDataIn,
	output logic nCd1,
	output logic nCd2,
	output logic nWp
);

	logic [7:0] mem [0:2047];	// 2 KB card

	// Fill from the whole address, stale reads stand out
	initial
	begin
		for (int i = 0; i < 2048; i++)
			mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
	end

	assign nCd1 = !inserted[1];	// Grounded when seated
	assign nCd2 = !inserted[0];
	assign nWp = !protect;

	// Card drives its data only while selected and read
	assign cardDataIn = (!nCrdc && !nCrdo) ? mem[cardAddr[10:0]] : 8'hFF;

	// Byte stored as WE rises
	always @(posedge nCardWe)
	begin
		if (!nCrdc && cardDataOe)
			mem[cardAddr[10:0]] = cardDataOut;
	end

endmodule

// ==== neoIoTb.sv ====
`timescale 1ns/10ps

module neoIoTb;

	localparam int MAX_ENTRIES = 32;
	localparam int TIMEOUT = 40;		// Cycles allowed per DTACK edge

	logic mclk;
	logic rst;
	logic [23:1] addr;
	logic [15:0] dataIn;
	logic [15:0] dataOut;
	logic rw, nAs, nUds, nLds, nDtack;
	logic [neoIoPkg::CARD_ADDR_W-1:0] cardAddr;
	logic [7:0] cardDataOut;
	logic [7:0] cardDataIn;
	logic nCrdc, nCrdo, nCardWe, cardDataOe;
	logic nCd1, nCd2, nWp;
	logic [1:0] inserted;
	logic protect;
	logic [7:0] dipSw;
	logic [3:0] elOut;
	logic [7:0] ledOut1, ledOut2;

	// Stimulus and expectation table
	bit tRead [MAX_ENTRIES];
	bit tProt [MAX_ENTRIES];
	bit tStrobe [MAX_ENTRIES];			// nCrdc expected to fall
	logic [23:1] tAddr [MAX_ENTRIES];
	logic [15:0] tData [MAX_ENTRIES];
	logic [15:0] tExpRd [MAX_ENTRIES];
	logic [1:0] tLanes [MAX_ENTRIES];	// {nUds, nLds}
	logic [1:0] tCard [MAX_ENTRIES];
	logic [7:0] tDip [MAX_ENTRIES];
	logic [19:0] tExpLed [MAX_ENTRIES];	// {elOut, ledOut1, ledOut2}
	int tLat [MAX_ENTRIES];				// Falling edges from strobe to DTACK
	int tMemIdx [MAX_ENTRIES];			// Negative skips the array check
	logic [7:0] tMemVal [MAX_ENTRIES];
	int numEntries;

	// Expected state while the table is built
	logic [1:0] curCard;
	bit curProt;
	logic [7:0] curDip, expStored, expLed1, expLed2;
	logic [3:0] expEl;

	int valueErrors, timeouts;
	bit aborted;

	neoIoTop i_dut
	(
		.mclk(mclk), .rst(rst), .addr(addr), .dataIn(dataIn), .rw(rw), .nAs(nAs),
		.nUds(nUds), .nLds(nLds), .dataOut(dataOut), .nDtack(nDtack),
		.cardAddr(cardAddr), .cardDataOut(cardDataOut), .nCrdc(nCrdc), .nCrdo(nCrdo),
		.nCardWe(nCardWe), .cardDataOe(cardDataOe), .cardDataIn(cardDataIn),
		.nCd1(nCd1), .nCd2(nCd2), .nWp(nWp), .dipSw(dipSw), .elOut(elOut),
		.ledOut1(ledOut1), .ledOut2(ledOut2)
	);

	neoMemcardModel i_card
	(
		.cardAddr(cardAddr), .cardDataOut(cardDataOut), .nCrdc(nCrdc), .nCrdo(nCrdo),
		.nCardWe(nCardWe), .cardDataOe(cardDataOe), .inserted(inserted),
		.protect(protect), .cardDataIn(cardDataIn), .nCd1(nCd1), .nCd2(nCd2), .nWp(nWp)
	);

	initial
	begin
		mclk = 1'b0;
		forever #2 mclk = ~mclk;	// 4 ns period
	end

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("error at %0t ns: %s expected %0h got %0h", $time, name, expVal, actVal);
		valueErrors++;
	endtask

	task automatic addEntry(input bit rd, input logic [23:1] a, input logic [15:0] wd,
		input logic [1:0] lanes, input logic [15:0] expRd, input int memIdx,
		input logic [7:0] memVal);
		bit inCard;
		inCard = (a >= neoIoPkg::CARD_BASE) && (a <= neoIoPkg::CARD_LIMIT);
		tRead[numEntries] = rd;
		tAddr[numEntries] = a;
		tData[numEntries] = wd;
		tLanes[numEntries] = lanes;
		tCard[numEntries] = curCard;
		tProt[numEntries] = curProt;
		tDip[numEntries] = curDip;
		tExpRd[numEntries] = expRd;
		tExpLed[numEntries] = {expEl, expLed1, expLed2};
		// Strobe edge, DECODE, WAIT entry and DTACK, plus the region's waits
		tLat[numEntries] = 4 + (inCard ? 2 : 0);
		tStrobe[numEntries] = inCard && (curCard == 2'b11);	// Both detects needed
		tMemIdx[numEntries] = memIdx;
		tMemVal[numEntries] = memVal;
		numEntries++;
	endtask

	task automatic ledWrite(input logic [7:0] b, input logic [1:0] lanes);
		if (!lanes[0])
			expStored = b;	// Low lane only
		addEntry(1'b0, neoIoPkg::LED_DATA_ADDR, {8'($urandom), b}, lanes, 16'h0, -1, 8'h0);
	endtask

	task automatic latchCmd(input bit l2, input bit l1, input bit el);
		neoIoPkg::ledWord_u cmd;
		cmd.raw = 8'h00;
		cmd.ctrl.loadLed2 = l2;
		cmd.ctrl.loadLed1 = l1;
		cmd.ctrl.loadEl = el;
		if (el)
			expEl = expStored[3:0];	// Low nibble to the EL panel
		if (l1)
			expLed1 = expStored;
		if (l2)
			expLed2 = expStored;
		addEntry(1'b0, neoIoPkg::LED_LATCH_ADDR, {8'h00, cmd.raw}, 2'b10, 16'h0, -1, 8'h0);
	endtask

	// One 68K cycle, strobes out to DTACK back high
	task automatic busCycle(input int i);
		int cycles;
		bit sawCrdc;
		@(negedge mclk);
		addr = tAddr[i];
		rw = tRead[i];
		dataIn = tData[i];
		dipSw = tDip[i];
		inserted = tCard[i];
		protect = tProt[i];
		nAs = 1'b0;
		{nUds, nLds} = tLanes[i];
		cycles = 0;
		sawCrdc = 1'b0;
		while (nDtack && cycles < TIMEOUT)
		begin
			@(negedge mclk);
			cycles++;
			if (!nCrdc)
				sawCrdc = 1'b1;
		end
		if (nDtack)
		begin
			$display("Timeout: entry %0d got no DTACK within %0d cycles", i, TIMEOUT);
			timeouts++;
			aborted = 1'b1;
		end
		else
		begin
			if (cycles != tLat[i])
				reportMismatch("dtackLatency", tLat[i], cycles);
			if (tRead[i] && dataOut !== tExpRd[i])
				reportMismatch("dataOut", tExpRd[i], dataOut);
			if (elOut !== tExpLed[i][19:16])
				reportMismatch("elOut", tExpLed[i][19:16], elOut);
			if (ledOut1 !== tExpLed[i][15:8])
				reportMismatch("ledOut1", tExpLed[i][15:8], ledOut1);
			if (ledOut2 !== tExpLed[i][7:0])
				reportMismatch("ledOut2", tExpLed[i][7:0], ledOut2);
			if (sawCrdc != tStrobe[i])
				reportMismatch("nCrdcActive", tStrobe[i], sawCrdc);
			if (tMemIdx[i] >= 0 && i_card.mem[tMemIdx[i]] !== tMemVal[i])
				reportMismatch("cardMem", tMemVal[i], i_card.mem[tMemIdx[i]]);
			nAs = 1'b1;		// End of cycle
			nUds = 1'b1;
			nLds = 1'b1;
			cycles = 0;
			while (!nDtack && cycles < TIMEOUT)
			begin
				@(negedge mclk);
				cycles++;
			end
			if (!nDtack)
			begin
				$display("Timeout: entry %0d kept DTACK low after AS was released", i);
				timeouts++;
				aborted = 1'b1;
			end
		end
	endtask

	initial
	begin
		logic [7:0] v1, v2;
		int off1, off2;
		rst = 1'b1;
		addr = '0;
		dataIn = '0;
		rw = 1'b1;
		nAs = 1'b1;
		nUds = 1'b1;
		nLds = 1'b1;
		dipSw = 8'h00;
		inserted = 2'b11;
		protect = 1'b0;
		valueErrors = 0;
		timeouts = 0;
		aborted = 1'b0;
		numEntries = 0;
		curCard = 2'b11;
		curProt = 1'b0;
		curDip = 8'h00;
		expStored = 8'h00;
		expEl = 4'h0;
		expLed1 = 8'h00;
		expLed2 = 8'h00;
		void'($urandom(54));

		repeat (10) @(negedge mclk);
		// Idle outputs straight out of reset
		if (nDtack !== 1'b1)
			reportMismatch("nDtack", 1, nDtack);
		if ({nCrdc, nCrdo, nCardWe} !== 3'b111)
			reportMismatch("nCrdc/nCrdo/nCardWe", 3'b111, {nCrdc, nCrdo, nCardWe});
		if (cardDataOe !== 1'b0)
			reportMismatch("cardDataOe", 0, cardDataOe);
		if ({elOut, ledOut1, ledOut2} !== 20'h0)
			reportMismatch("elOut/ledOut1/ledOut2", 0, {elOut, ledOut1, ledOut2});
		rst = 1'b0;

		repeat (4)
		begin
			curDip = 8'($urandom);
			addEntry(1'b1, neoIoPkg::DIPSW_ADDR, 16'h0, 2'b00, {8'hFF, curDip}, -1, 8'h0);
		end
		ledWrite(8'($urandom), 2'b10);
		latchCmd(1'b0, 1'b0, 1'b1);
		latchCmd(1'b0, 1'b1, 1'b0);
		ledWrite(8'($urandom), 2'b10);
		latchCmd(1'b1, 1'b0, 1'b1);
		latchCmd(1'b0, 1'b0, 1'b0);		// No load bit set
		ledWrite(8'($urandom), 2'b01);	// Upper lane only, stored byte kept
		latchCmd(1'b1, 1'b1, 1'b0);

		off1 = int'($urandom % 2048);
		off2 = (off1 + 1 + int'($urandom % 2046)) % 2048;	// Never equal to off1
		v1 = 8'($urandom);
		v2 = 8'($urandom);
		addEntry(1'b0, neoIoPkg::CARD_BASE + 23'(off1), {8'($urandom), v1}, 2'b10,
			16'h0, off1, v1);
		addEntry(1'b1, neoIoPkg::CARD_BASE + 23'(off1), 16'h0, 2'b10, {8'hFF, v1}, off1, v1);
		addEntry(1'b0, neoIoPkg::CARD_BASE + 23'(off2), {8'($urandom), v2}, 2'b10,
			16'h0, off2, v2);
		addEntry(1'b1, neoIoPkg::CARD_BASE + 23'(off2), 16'h0, 2'b10, {8'hFF, v2}, off2, v2);
		curProt = 1'b1;
		addEntry(1'b0, neoIoPkg::CARD_BASE + 23'(off1), {8'h00, ~v1}, 2'b10, 16'h0, off1, v1);
		addEntry(1'b1, neoIoPkg::CARD_BASE + 23'(off1), 16'h0, 2'b10, {8'hFF, v1}, off1, v1);
		curProt = 1'b0;
		curCard = 2'b01;			// First detect open
		addEntry(1'b1, neoIoPkg::CARD_BASE + 23'(off2), 16'h0, 2'b10, 16'hFFFF, -1, 8'h0);
		curCard = 2'b10;
		addEntry(1'b1, neoIoPkg::CARD_BASE + 23'(off2), 16'h0, 2'b10, 16'hFFFF, -1, 8'h0);
		curCard = 2'b11;

		addEntry(1'b1, 23'h000200, 16'h0, 2'b00, 16'hFFFF, -1, 8'h0);	// Unmapped
		addEntry(1'b1, 23'h7FFFF0, 16'h0, 2'b00, 16'hFFFF, -1, 8'h0);
		addEntry(1'b1, neoIoPkg::LED_DATA_ADDR, 16'h0, 2'b00, 16'hFFFF, -1, 8'h0);
		addEntry(1'b1, neoIoPkg::LED_LATCH_ADDR, 16'h0, 2'b00, 16'hFFFF, -1, 8'h0);

		for (int i = 0; i < numEntries && !aborted; i++)
			busCycle(i);

		$display("Errors: %0d value, %0d timeout", valueErrors, timeouts);
		if (valueErrors == 0 && timeouts == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== neoIo.f ====
neoIoPkg.sv
neoWaitTimer.sv
neoBusCtrl.sv
neoCabIo.sv
neoMemcard.sv
neoIoTop.sv
neoMemcardModel.sv
neoIoTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= neoIoTb
FILELIST ?= neoIo.f
BUILD_DIR ?= obj_dir
SEED ?= 54
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

.PHONY: simulate clean
